/* decode_defines.svh */
// ==========================================================
// Shared widths and fixed values for the RV32I decode stage
// Included by the decode package and by the testbench
// Guarded so repeated inclusion is harmless
// ==========================================================

`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Data word width
`define DEC_XLEN 32

// Register file index width, x0 to x31
`define DEC_REG_IDX_W 5

// Major opcode field, instruction bits 6 down to 2
`define DEC_OPCODE_W 5

// Marker value on the immediate when the format carries none
`define DEC_IMM_POISON 32'hDEADBEEF

`endif

/* decode_pkg.sv */
// ==========================================================
// Types for the RV32I decode stage
// Word and index types plus the enums for opcodes, formats
// and every control field sent on to execute
// Import with a wildcard import in the module header
// ==========================================================

`include "decode_defines.svh"

package decode_pkg;

    // Basic datapath types
    typedef logic [`DEC_XLEN-1:0]      word_t;
    typedef logic [`DEC_REG_IDX_W-1:0] reg_idx_t;

    // RV32 major opcodes, instr[6:2]
    typedef enum logic [`DEC_OPCODE_W-1:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    // Instruction encoding formats
    typedef enum logic [2:0] {
        INSTR_FORMAT_BAD = 3'b000,
        INSTR_FORMAT_R,
        INSTR_FORMAT_I,
        INSTR_FORMAT_S,
        INSTR_FORMAT_B,
        INSTR_FORMAT_U,
        INSTR_FORMAT_J,
        INSTR_FORMAT_SYS
    } instr_format_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_OP_ADD = 4'h0,
        ALU_OP_SUB,
        ALU_OP_SLL,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_XOR,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_OR,
        ALU_OP_AND
    } alu_op_e;

    // ALU operand selects
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1 = 2'b00,
        ALU_OP1_SRC_PC,
        ALU_OP1_SRC_ZERO
    } alu_op1_src_e;

    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS2 = 2'b00,
        ALU_OP2_SRC_IMM,
        ALU_OP2_SRC_FOUR
    } alu_op2_src_e;

    // Writeback source for rd
    typedef enum logic {
        RD_SRC_ALU = 1'b0,
        RD_SRC_MEM = 1'b1
    } rd_src_e;

    // Memory access kind
    typedef enum logic [1:0] {
        MEM_OP_NONE = 2'b00,
        MEM_OP_LOAD,
        MEM_OP_STORE
    } mem_op_e;

    // Access size, straight from funct3[1:0]
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'b00,
        MEM_SIZE_HALF = 2'b01,
        MEM_SIZE_WORD = 2'b10
    } mem_size_e;

    // Control transfer kind
    typedef enum logic [1:0] {
        BRANCH_NONE = 2'b00,
        BRANCH_COND,
        BRANCH_JALR,
        BRANCH_JAL
    } branch_e;

    // Branch compare, encoded as funct3
    typedef enum logic [2:0] {
        CMP_OP_EQ  = 3'b000,
        CMP_OP_NE  = 3'b001,
        CMP_OP_LT  = 3'b100,
        CMP_OP_GE  = 3'b101,
        CMP_OP_LTU = 3'b110,
        CMP_OP_GEU = 3'b111
    } cmp_op_e;

endpackage

/* decode_imm_gen.sv */
// ==========================================================
// Opcode, format and immediate decode for RV32I
// Purely combinational, fed with the held instruction word
// Returns the major opcode for the control decoder
// ==========================================================

`include "decode_defines.svh"

module decode_imm_gen
    import decode_pkg::*;
(
    input  word_t   instr,
    output opcode_e opcode,
    output word_t   imm
);

    instr_format_e instr_format;

    // Opcode is instr[6:2], low two bits handled by the control decoder
    assign opcode = opcode_e'(instr[6:2]);

    // Format lookup per major opcode
    always_comb begin
        case (opcode)
            OPCODE_OP, OPCODE_AMO: begin
                instr_format = INSTR_FORMAT_R;
            end
            OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_JALR, OPCODE_MISC_MEM: begin
                instr_format = INSTR_FORMAT_I;
            end
            OPCODE_STORE: begin
                instr_format = INSTR_FORMAT_S;
            end
            OPCODE_BRANCH: begin
                instr_format = INSTR_FORMAT_B;
            end
            OPCODE_AUIPC, OPCODE_LUI: begin
                instr_format = INSTR_FORMAT_U;
            end
            OPCODE_JAL: begin
                instr_format = INSTR_FORMAT_J;
            end
            OPCODE_SYSTEM: begin
                instr_format = INSTR_FORMAT_SYS;
            end
            default: begin
                instr_format = INSTR_FORMAT_BAD;
            end
        endcase
    end

    // Immediate assembly, sign bit is always instr[31]
    always_comb begin
        case (instr_format)
            INSTR_FORMAT_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            INSTR_FORMAT_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            INSTR_FORMAT_B: begin
                // Halfword aligned offset
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            INSTR_FORMAT_U: begin
                imm = {instr[31:12], 12'h000};
            end
            INSTR_FORMAT_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                // R, SYS and unknown formats carry no immediate
                imm = `DEC_IMM_POISON;
            end
        endcase
    end

endmodule

/* decode_ctrl_gen.sv */
// ==========================================================
// Control word generation for the RV32I decode stage
// Purely combinational, takes the held word and its opcode
// Drives the execute controls and the illegal flag
// SYSTEM and AMO are not supported and report illegal
// ==========================================================

module decode_ctrl_gen
    import decode_pkg::*;
(
    input  word_t        instr,
    input  opcode_e      opcode,
    output rd_src_e      rd_src,
    output logic         rd_we,
    output alu_op_e      alu_op,
    output alu_op1_src_e alu_op1_src,
    output alu_op2_src_e alu_op2_src,
    output mem_op_e      mem_op,
    output logic         mem_signed,
    output mem_size_e    mem_size,
    output branch_e      branch,
    output cmp_op_e      cmp_op,
    output logic         fence,
    output logic         illegal_instr
);

    logic [2:0] funct3;
    logic       funct7_b5;
    logic       rd_is_x0;
    logic       bad_opcode;
    alu_op_e    alu_op_funct;

    // Fields reused by several opcodes
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rd_is_x0  = (instr[11:7] == 5'd0);

    // Shared funct3 to ALU op mapping for OP and OP-IMM
    // Alternate bit picks SRA, and SUB only for OP
    always_comb begin
        case (funct3)
            3'b000: begin
                alu_op_funct = (funct7_b5 && opcode == OPCODE_OP) ? ALU_OP_SUB : ALU_OP_ADD;
            end
            3'b001:  alu_op_funct = ALU_OP_SLL;
            3'b010:  alu_op_funct = ALU_OP_SLT;
            3'b011:  alu_op_funct = ALU_OP_SLTU;
            3'b100:  alu_op_funct = ALU_OP_XOR;
            3'b101:  alu_op_funct = funct7_b5 ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  alu_op_funct = ALU_OP_OR;
            default: alu_op_funct = ALU_OP_AND;
        endcase
    end

    // Per opcode control, everything zero unless set below
    always_comb begin
        rd_src      = RD_SRC_ALU;
        rd_we       = 1'b0;
        alu_op      = ALU_OP_ADD;
        alu_op1_src = ALU_OP1_SRC_RS1;
        alu_op2_src = ALU_OP2_SRC_RS2;
        mem_op      = MEM_OP_NONE;
        mem_signed  = 1'b0;
        mem_size    = MEM_SIZE_BYTE;
        branch      = BRANCH_NONE;
        cmp_op      = CMP_OP_EQ;
        fence       = 1'b0;
        bad_opcode  = 1'b0;

        case (opcode)
            OPCODE_OP: begin
                rd_we       = !rd_is_x0;
                alu_op      = alu_op_funct;
            end
            OPCODE_OP_IMM: begin
                rd_we       = !rd_is_x0;
                alu_op2_src = ALU_OP2_SRC_IMM;
                alu_op      = alu_op_funct;
            end
            OPCODE_LOAD: begin
                // Address is rs1 plus offset
                rd_src      = RD_SRC_MEM;
                rd_we       = !rd_is_x0;
                alu_op2_src = ALU_OP2_SRC_IMM;
                mem_op      = MEM_OP_LOAD;
                mem_signed  = !funct3[2];
                mem_size    = mem_size_e'(funct3[1:0]);
            end
            OPCODE_STORE: begin
                // No rd for stores
                alu_op2_src = ALU_OP2_SRC_IMM;
                mem_op      = MEM_OP_STORE;
                mem_size    = mem_size_e'(funct3[1:0]);
            end
            OPCODE_BRANCH: begin
                branch      = BRANCH_COND;
                cmp_op      = cmp_op_e'(funct3);
            end
            OPCODE_JAL: begin
                // Link value is PC plus 4
                rd_we       = !rd_is_x0;
                alu_op1_src = ALU_OP1_SRC_PC;
                alu_op2_src = ALU_OP2_SRC_FOUR;
                branch      = BRANCH_JAL;
            end
            OPCODE_JALR: begin
                rd_we       = !rd_is_x0;
                alu_op1_src = ALU_OP1_SRC_PC;
                alu_op2_src = ALU_OP2_SRC_FOUR;
                branch      = BRANCH_JALR;
            end
            OPCODE_LUI: begin
                rd_we       = !rd_is_x0;
                alu_op1_src = ALU_OP1_SRC_ZERO;
                alu_op2_src = ALU_OP2_SRC_IMM;
            end
            OPCODE_AUIPC: begin
                rd_we       = !rd_is_x0;
                alu_op1_src = ALU_OP1_SRC_PC;
                alu_op2_src = ALU_OP2_SRC_IMM;
            end
            OPCODE_MISC_MEM: begin
                // Any fence flushes everything
                fence       = 1'b1;
            end
            default: begin
                // SYSTEM, AMO and unknown opcodes
                bad_opcode  = 1'b1;
            end
        endcase
    end

    // Compressed or malformed encodings are illegal too
    assign illegal_instr = bad_opcode || (instr[1:0] != 2'b11);

endmodule

/* decode_stage.sv */
// ==========================================================
// RV32I decode stage top level
// Holds the fetched word and PC in a stall gated register
// Drives register file read indices and forwards the values
// Outputs are combinational from the register, one cycle
// after acceptance, and qualified by out_valid
// ==========================================================

module decode_stage
    import decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // Hazard control
    input  logic         stall,
    input  logic         flush,

    // From fetch
    input  logic         in_valid,
    input  word_t        in_instr,
    input  word_t        in_pc,

    // Register file read ports
    output reg_idx_t     rs1_idx,
    output reg_idx_t     rs2_idx,
    input  word_t        rs1_val_in,
    input  word_t        rs2_val_in,

    // To execute
    output logic         out_valid,
    output word_t        out_pc,
    output reg_idx_t     rd_idx,
    output word_t        rs1_val,
    output word_t        rs2_val,
    output word_t        imm,
    output rd_src_e      rd_src,
    output logic         rd_we,
    output alu_op_e      alu_op,
    output alu_op1_src_e alu_op1_src,
    output alu_op2_src_e alu_op2_src,
    output mem_op_e      mem_op,
    output logic         mem_signed,
    output mem_size_e    mem_size,
    output branch_e      branch,
    output cmp_op_e      cmp_op,
    output logic         fence,
    output logic         illegal_instr
);

    logic    valid_q;
    word_t   instr_q;
    word_t   pc_q;
    opcode_e opcode;

    // Held valid, frozen while stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid;
        end
    end

    // Payload register, same enable as the valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            instr_q <= in_instr;
            pc_q    <= in_pc;
        end
    end

    // Flush kills this cycle, the next edge overwrites the entry
    assign out_valid = valid_q && !flush && !stall;
    assign out_pc    = pc_q;

    // Register indices from the held word
    assign rs1_idx = instr_q[19:15];
    assign rs2_idx = instr_q[24:20];
    assign rd_idx  = instr_q[11:7];

    // Register file answers in the same cycle
    assign rs1_val = rs1_val_in;
    assign rs2_val = rs2_val_in;

    decode_imm_gen decode_imm_gen_i (
        .instr  (instr_q),
        .opcode (opcode),
        .imm    (imm)
    );

    decode_ctrl_gen decode_ctrl_gen_i (
        .instr         (instr_q),
        .opcode        (opcode),
        .rd_src        (rd_src),
        .rd_we         (rd_we),
        .alu_op        (alu_op),
        .alu_op1_src   (alu_op1_src),
        .alu_op2_src   (alu_op2_src),
        .mem_op        (mem_op),
        .mem_signed    (mem_signed),
        .mem_size      (mem_size),
        .branch        (branch),
        .cmp_op        (cmp_op),
        .fence         (fence),
        .illegal_instr (illegal_instr)
    );

endmodule

/* tb_clk_gen.sv */
// ==========================================================
// Testbench clock and reset generator
// Free running clock, rst_n held low for the first cycles
// and released with a non-blocking update on a rising edge
// ==========================================================

module tb_clk_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    // Clock toggles every half period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset low for the first RESET_CYCLES rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tb_decode_stage.sv */
// ==========================================================
// Testbench for the RV32I decode stage
// Random instruction stream from an LFSR with random stall
// and flush
// Every cycle is checked against a decode model
// Register file modeled as index repeated in every byte
// ==========================================================

`include "decode_defines.svh"

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS  = 2000;

    logic         clk;
    logic         rst_n;
    logic         stall;
    logic         flush;
    logic         in_valid;
    word_t        in_instr;
    word_t        in_pc;
    reg_idx_t     rs1_idx;
    reg_idx_t     rs2_idx;
    word_t        rs1_val_in;
    word_t        rs2_val_in;
    logic         out_valid;
    word_t        out_pc;
    reg_idx_t     rd_idx;
    word_t        rs1_val;
    word_t        rs2_val;
    word_t        imm;
    rd_src_e      rd_src;
    logic         rd_we;
    alu_op_e      alu_op;
    alu_op1_src_e alu_op1_src;
    alu_op2_src_e alu_op2_src;
    mem_op_e      mem_op;
    logic         mem_signed;
    mem_size_e    mem_size;
    branch_e      branch;
    cmp_op_e      cmp_op;
    logic         fence;
    logic         illegal_instr;

    // LFSR state from the fixed seed
    logic [31:0]  lfsr_state = 32'd79;

    // Values currently applied to the DUT
    logic         drv_stall;
    logic         drv_flush;
    logic         drv_valid;
    word_t        drv_instr;
    word_t        drv_pc;

    // Model of the held entry
    logic         held_valid;
    word_t        held_instr;
    word_t        held_pc;
    int           checked;

    // Expected decode of the held word
    word_t        exp_imm;
    logic         exp_rd_src;
    logic         exp_rd_we;
    logic [3:0]   exp_alu_op;
    logic [1:0]   exp_op1_src;
    logic [1:0]   exp_op2_src;
    logic [1:0]   exp_mem_op;
    logic         exp_mem_signed;
    logic [1:0]   exp_mem_size;
    logic [1:0]   exp_branch;
    logic [2:0]   exp_cmp_op;
    logic         exp_fence;
    logic         exp_illegal;

    tb_clk_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (4)
    ) tb_clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_stage decode_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_pc         (in_pc),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .rs1_val_in    (rs1_val_in),
        .rs2_val_in    (rs2_val_in),
        .out_valid     (out_valid),
        .out_pc        (out_pc),
        .rd_idx        (rd_idx),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .imm           (imm),
        .rd_src        (rd_src),
        .rd_we         (rd_we),
        .alu_op        (alu_op),
        .alu_op1_src   (alu_op1_src),
        .alu_op2_src   (alu_op2_src),
        .mem_op        (mem_op),
        .mem_signed    (mem_signed),
        .mem_size      (mem_size),
        .branch        (branch),
        .cmp_op        (cmp_op),
        .fence         (fence),
        .illegal_instr (illegal_instr)
    );

    // Register file contents as a fixed function of the index
    function automatic word_t regfile_value(input reg_idx_t idx);
        return {4{3'b000, idx}};
    endfunction

    assign rs1_val_in = regfile_value(rs1_idx);
    assign rs2_val_in = regfile_value(rs2_idx);

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Kept opcodes plus SYSTEM and AMO
    // Remaining selects give random low seven bits
    function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:    return 7'b0000011;
            4'd1:    return 7'b0001111;
            4'd2:    return 7'b0010011;
            4'd3:    return 7'b0010111;
            4'd4:    return 7'b0100011;
            4'd5:    return 7'b0110011;
            4'd6:    return 7'b0110111;
            4'd7:    return 7'b1100011;
            4'd8:    return 7'b1100111;
            4'd9:    return 7'b1101111;
            4'd10:   return 7'b1110011;
            4'd11:   return 7'b0101111;
            default: return lfsr_bits(7);
        endcase
    endfunction

    // Table opcode for most words
    // One in eight is a fully random word
    function automatic word_t make_instr();
        logic [24:0] upper;
        if (lfsr_bits(3) == 0) begin
            return lfsr_bits(32);
        end
        upper = lfsr_bits(25);
        return {upper, pick_opcode(lfsr_bits(4))};
    endfunction

    // RV32I funct3 to ALU operation
    // SUB only exists in the register form
    function automatic logic [3:0] alu_expect(input logic [2:0] f3, input logic alt,
                                              input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  return ALU_OP_SLL;
            3'b010:  return ALU_OP_SLT;
            3'b011:  return ALU_OP_SLTU;
            3'b100:  return ALU_OP_XOR;
            3'b101:  return alt ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  return ALU_OP_OR;
            default: return ALU_OP_AND;
        endcase
    endfunction

    // Reference decode from the RV32I encoding rules
    function automatic void predict_decode(input word_t w);
        logic [2:0] f3;
        logic       rd_nz;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        f3    = w[14:12];
        rd_nz = (w[11:7] != 5'd0);
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

        exp_imm        = `DEC_IMM_POISON;
        exp_rd_src     = RD_SRC_ALU;
        exp_rd_we      = 1'b0;
        exp_alu_op     = ALU_OP_ADD;
        exp_op1_src    = ALU_OP1_SRC_RS1;
        exp_op2_src    = ALU_OP2_SRC_RS2;
        exp_mem_op     = MEM_OP_NONE;
        exp_mem_signed = 1'b0;
        exp_mem_size   = 2'b00;
        exp_branch     = BRANCH_NONE;
        exp_cmp_op     = 3'b000;
        exp_fence      = 1'b0;
        exp_illegal    = (w[1:0] != 2'b11);

        case (w[6:2])
            5'b01100: begin
                exp_rd_we  = rd_nz;
                exp_alu_op = alu_expect(f3, w[30], 1'b1);
            end
            5'b00100: begin
                exp_rd_we   = rd_nz;
                exp_alu_op  = alu_expect(f3, w[30], 1'b0);
                exp_op2_src = ALU_OP2_SRC_IMM;
                exp_imm     = imm_i;
            end
            5'b00000: begin
                exp_rd_src     = RD_SRC_MEM;
                exp_rd_we      = rd_nz;
                exp_op2_src    = ALU_OP2_SRC_IMM;
                exp_mem_op     = MEM_OP_LOAD;
                exp_mem_signed = !f3[2];
                exp_mem_size   = f3[1:0];
                exp_imm        = imm_i;
            end
            5'b01000: begin
                exp_op2_src  = ALU_OP2_SRC_IMM;
                exp_mem_op   = MEM_OP_STORE;
                exp_mem_size = f3[1:0];
                exp_imm      = imm_s;
            end
            5'b11000: begin
                exp_branch = BRANCH_COND;
                exp_cmp_op = f3;
                exp_imm    = imm_b;
            end
            5'b11011, 5'b11001: begin
                // Link address is PC plus 4 for both jumps
                exp_rd_we   = rd_nz;
                exp_op1_src = ALU_OP1_SRC_PC;
                exp_op2_src = ALU_OP2_SRC_FOUR;
                exp_branch  = w[3] ? BRANCH_JAL : BRANCH_JALR;
                exp_imm     = w[3] ? imm_j : imm_i;
            end
            5'b01101, 5'b00101: begin
                // LUI adds to zero and AUIPC to the PC
                exp_rd_we   = rd_nz;
                exp_op1_src = w[5] ? ALU_OP1_SRC_ZERO : ALU_OP1_SRC_PC;
                exp_op2_src = ALU_OP2_SRC_IMM;
                exp_imm     = imm_u;
            end
            5'b00011: begin
                exp_fence = 1'b1;
                exp_imm   = imm_i;
            end
            default: begin
                exp_illegal = 1'b1;
            end
        endcase
    endfunction

    // Single compare point for every check
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Compare DUT outputs with the model at the falling edge
    task automatic check_outputs();
        check_value("out_valid", held_valid && !drv_stall && !drv_flush, out_valid);
        if (held_valid) begin
            predict_decode(held_instr);
            check_value("out_pc", held_pc, out_pc);
            check_value("rs1_idx", held_instr[19:15], rs1_idx);
            check_value("rs2_idx", held_instr[24:20], rs2_idx);
            check_value("rd_idx", held_instr[11:7], rd_idx);
            check_value("rs1_val", regfile_value(held_instr[19:15]), rs1_val);
            check_value("rs2_val", regfile_value(held_instr[24:20]), rs2_val);
            check_value("imm", exp_imm, imm);
            check_value("rd_src", exp_rd_src, rd_src);
            check_value("rd_we", exp_rd_we, rd_we);
            check_value("alu_op", exp_alu_op, alu_op);
            check_value("alu_op1_src", exp_op1_src, alu_op1_src);
            check_value("alu_op2_src", exp_op2_src, alu_op2_src);
            check_value("mem_op", exp_mem_op, mem_op);
            check_value("mem_signed", exp_mem_signed, mem_signed);
            check_value("mem_size", exp_mem_size, mem_size);
            check_value("branch", exp_branch, branch);
            check_value("cmp_op", exp_cmp_op, cmp_op);
            check_value("fence", exp_fence, fence);
            check_value("illegal_instr", exp_illegal, illegal_instr);
        end
    endtask

    // Watchdog bound of 20 cycles per instruction
    initial begin
        #(NUM_TESTS * 20 * CLK_PERIOD);
        $display("Timeout: not all instructions were checked in time");
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        // Valid is high through reset
        // Only the reset then keeps out_valid low
        stall      = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b1;
        in_instr   = '0;
        in_pc      = '0;
        drv_stall  = 1'b0;
        drv_flush  = 1'b0;
        drv_valid  = 1'b1;
        drv_instr  = '0;
        drv_pc     = '0;
        held_valid = 1'b0;
        held_instr = '0;
        held_pc    = '0;
        checked    = 0;

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("out_valid after reset", 1'b0, out_valid);

        while (checked < NUM_TESTS) begin
            @(posedge clk);
            // Register loads what was applied unless stalled
            if (!drv_stall) begin
                held_valid = drv_valid;
                held_instr = drv_instr;
                held_pc    = drv_pc;
            end

            // Next stimulus with stall and flush never together
            drv_stall = (lfsr_bits(3) == 0);
            drv_flush = !drv_stall && (lfsr_bits(4) == 0);
            drv_valid = (lfsr_bits(3) != 0);
            drv_instr = make_instr();
            drv_pc    = {lfsr_bits(30), 2'b00};

            stall    <= drv_stall;
            flush    <= drv_flush;
            in_valid <= drv_valid;
            in_instr <= drv_instr;
            in_pc    <= drv_pc;

            @(negedge clk);
            check_outputs();
            if (held_valid && !drv_stall && !drv_flush) begin
                checked++;
            end
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
decode_pkg.sv
decode_imm_gen.sv
decode_ctrl_gen.sv
decode_stage.sv
tb_clk_gen.sv
tb_decode_stage.sv
